/* rtl/corePkg.sv */
package corePkg;

	// major opcodes the core understands, anything else decodes to a bubble
	typedef enum logic [6:0] {
		OPREG    = 7'b0110011,	// register-register alu ops
		OPIMM    = 7'b0010011,	// alu ops with I immediate, incl shift-immediates
		OPBRANCH = 7'b1100011,	// beq and bne only
		OPJAL    = 7'b1101111
	} opcodeT;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
	} aluOpT;

	typedef enum logic [1:0] {REG, IMM, SHAMT} bSelT;	// operand b source
	typedef enum logic [1:0] {SEQ, BRANCH, JUMP} pcSelT;	// next pc source
	typedef enum logic {ALU, LINK} resSelT;		// LINK commits pc+4

	// leaves decode as the stage-3 register
	typedef struct packed {
		logic        valid;
		logic        we;
		logic [4:0]  rd;
		aluOpT       aluOp;
		resSelT      resSel;
		pcSelT       pcSel;
		logic        bneq;	// branch on inequality
		bSelT        bSel;
		logic [4:0]  shamt;
		logic [31:0] iImm;
		logic [31:0] bImm;	// branch or jal offset
		logic [31:0] pc;
	} decodeCtrlT;

	// leaves issue, operands already selected
	typedef struct packed {
		logic        valid;
		logic        we;
		logic [4:0]  rd;
		aluOpT       aluOp;
		resSelT      resSel;
		pcSelT       pcSel;
		logic        bneq;
		logic [31:0] bImm;
		logic [31:0] pc;
		logic [31:0] opA;
		logic [31:0] opB;
	} issueOutT;

	// commit trace entry, also the register file write
	typedef struct packed {
		logic        valid;
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
		logic [31:0] pc;
	} commitT;

	// destination tag of an instruction further down the pipe
	typedef struct packed {
		logic       valid;
		logic       we;
		logic [4:0] rd;
	} writeTagT;

endpackage

/* rtl/wishbonePkg.sv */
package wishbonePkg;

	// master to slave, classic cycle
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;	// always low on the fetch port
		logic [31:0] adr;
	} wbReqT;

	// slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wbRspT;

endpackage

/* rtl/regFile.sv */
module regFile (
	input  logic        clk,
	input  logic        nrst,
	input  logic        we,
	input  logic [4:0]  writeAddr,
	input  logic [4:0]  sourceA,
	input  logic [4:0]  sourceB,
	input  logic [31:0] result,
	output logic [31:0] opA,
	output logic [31:0] opB
);

	logic [31:0] regs [32];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && writeAddr != 5'd0)	// x0 never written
			regs[writeAddr] <= result;
	end

	// combinational reads
	assign opA = (sourceA == 5'd0) ? 32'd0 : regs[sourceA];
	assign opB = (sourceB == 5'd0) ? 32'd0 : regs[sourceB];

endmodule

/* rtl/fetchUnit.sv */
module fetchUnit import wishbonePkg::*; #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        nrst,
	output wbReqT       wbReq,
	input  wbRspT       wbRsp,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] redirectPc,
	output logic        instrValid,
	output logic [31:0] instr,
	output logic [31:0] instrPc
);

	logic [31:0] pc;		// next address to request
	logic [31:0] reqAdr;		// address of the transfer on the bus
	logic        busy;		// cyc and stb up
	logic        discard;		// in-flight data belongs to a squashed path
	logic        held;		// ack arrived while decode was stalled
	logic [31:0] heldInstr;
	logic        done;
	logic        fresh;
	logic        startReq;

	assign done     = busy && wbRsp.ack;
	assign fresh    = done && !discard;	// ack carrying usable data
	// a new cycle may follow an ack on the same edge
	assign startReq = !redirect && !stall && !held && (!busy || wbRsp.ack);

	assign wbReq = '{cyc: busy, stb: busy, we: 1'b0, adr: reqAdr};

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc         <= resetPc;
			busy       <= 1'b0;
			discard    <= 1'b0;
			held       <= 1'b0;
			instrValid <= 1'b0;
		end
		else
		begin
			if (redirect)
				pc <= redirectPc;
			else if (startReq)
				pc <= pc + 32'd4;
			if (startReq)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			if (redirect)
				discard <= busy && !wbRsp.ack;	// still wait for the ack, then drop it
			else if (done)
				discard <= 1'b0;
			if (redirect)
			begin
				held       <= 1'b0;
				instrValid <= 1'b0;
			end
			else if (!stall)
			begin
				instrValid <= held || fresh;	// bubble when nothing arrived
				held       <= 1'b0;
			end
			else if (fresh)
				held <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clk)
	begin
		if (startReq)
			reqAdr <= pc;
		if (!redirect && !stall && (held || fresh))
		begin
			instr   <= held ? heldInstr : wbRsp.dat;
			instrPc <= reqAdr;	// no new request while held, so still valid
		end
		if (stall && fresh)
			heldInstr <= wbRsp.dat;
	end

endmodule

/* rtl/decodeStage.sv */
module decodeStage import corePkg::*; (
	input  logic           clk,
	input  logic           nrst,
	input  logic           instrValid,
	input  logic           flush,
	input  logic [31:0]    instr,
	input  logic [31:0]    instrPc,
	input  writeTagT [1:0] pipeWrites,	// [0] issue register, [1] commit register
	output logic           stall,
	output logic [4:0]     rs1,
	output logic [4:0]     rs2,
	output decodeCtrlT     ctrl
);

	opcodeT      opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [4:0]  src1;
	logic [4:0]  src2;
	logic [31:0] iImm;
	logic [31:0] bTypeImm;
	logic [31:0] jImm;
	logic        legal;
	logic        useRs1;
	logic        useRs2;
	logic        hazard1;
	logic        hazard2;
	writeTagT    ownTag;
	decodeCtrlT  nextCtrl;

	// true when tag will write the register src still has to read
	function automatic logic blocks(writeTagT tag, logic [4:0] src);
		return tag.valid && tag.we && (tag.rd != 5'd0) && (tag.rd == src);
	endfunction

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign src1   = instr[19:15];
	assign src2   = instr[24:20];

	assign iImm     = {{20{instr[31]}}, instr[31:20]};
	assign bTypeImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign jImm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb
	begin
		nextCtrl        = '0;
		nextCtrl.rd     = instr[11:7];
		nextCtrl.aluOp  = ADD;
		nextCtrl.resSel = ALU;
		nextCtrl.pcSel  = SEQ;
		nextCtrl.bSel   = REG;
		nextCtrl.shamt  = instr[24:20];
		nextCtrl.iImm   = iImm;
		nextCtrl.pc     = instrPc;
		legal  = 1'b1;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		case (opcode)
			OPREG:
			begin
				nextCtrl.we = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: nextCtrl.aluOp = ADD;
					{7'h20, 3'b000}: nextCtrl.aluOp = SUB;
					{7'h00, 3'b001}: nextCtrl.aluOp = SLL;
					{7'h00, 3'b010}: nextCtrl.aluOp = SLT;
					{7'h00, 3'b011}: nextCtrl.aluOp = SLTU;
					{7'h00, 3'b100}: nextCtrl.aluOp = XOR;
					{7'h00, 3'b101}: nextCtrl.aluOp = SRL;
					{7'h20, 3'b101}: nextCtrl.aluOp = SRA;
					{7'h00, 3'b110}: nextCtrl.aluOp = OR;
					{7'h00, 3'b111}: nextCtrl.aluOp = AND;
					default:         legal = 1'b0;
				endcase
			end
			OPIMM:
			begin
				nextCtrl.we   = 1'b1;
				nextCtrl.bSel = IMM;
				useRs1 = 1'b1;
				case (funct3)
					3'b000: nextCtrl.aluOp = ADD;
					3'b010: nextCtrl.aluOp = SLT;
					3'b011: nextCtrl.aluOp = SLTU;
					3'b100: nextCtrl.aluOp = XOR;
					3'b110: nextCtrl.aluOp = OR;
					3'b111: nextCtrl.aluOp = AND;
					default:	// shift-immediates take the shamt path
					begin
						nextCtrl.bSel = SHAMT;
						if (funct3 == 3'b001 && funct7 == 7'h00)
							nextCtrl.aluOp = SLL;
						else if (funct3 == 3'b101 && funct7 == 7'h00)
							nextCtrl.aluOp = SRL;
						else if (funct3 == 3'b101 && funct7 == 7'h20)
							nextCtrl.aluOp = SRA;
						else
							legal = 1'b0;
					end
				endcase
			end
			OPBRANCH:
			begin
				nextCtrl.rd    = 5'd0;	// rd bits hold part of the offset
				nextCtrl.pcSel = BRANCH;
				nextCtrl.bneq  = funct3[0];
				nextCtrl.bImm  = bTypeImm;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				legal  = (funct3[2:1] == 2'b00);	// beq or bne
			end
			OPJAL:
			begin
				nextCtrl.we     = 1'b1;
				nextCtrl.resSel = LINK;
				nextCtrl.pcSel  = JUMP;
				nextCtrl.bImm   = jImm;
			end
			default: legal = 1'b0;
		endcase
	end

	// hold the fetched instruction while an older one still has to write a source
	assign ownTag  = '{valid: ctrl.valid, we: ctrl.we, rd: ctrl.rd};
	assign hazard1 = useRs1 && (blocks(ownTag, src1) || blocks(pipeWrites[0], src1) ||
		blocks(pipeWrites[1], src1));
	assign hazard2 = useRs2 && (blocks(ownTag, src2) || blocks(pipeWrites[0], src2) ||
		blocks(pipeWrites[1], src2));
	assign stall   = instrValid && (hazard1 || hazard2);

	// stage-3 register, a stall or flush leaves a bubble
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			ctrl <= '0;
			rs1  <= 5'd0;
			rs2  <= 5'd0;
		end
		else
		begin
			ctrl       <= nextCtrl;
			ctrl.valid <= instrValid && legal && !stall && !flush;
			rs1        <= src1;	// register file read happens in stage 3
			rs2        <= src2;
		end
	end

endmodule

/* rtl/issueStage.sv */
module issueStage import corePkg::*; (
	input  logic       clk,
	input  logic       nrst,
	input  logic       flush,
	input  decodeCtrlT ctrl,	// stage-3 controls
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  commitT     wbCommit,	// write port from the commit register
	output issueOutT   issued
);

	decodeCtrlT  ctrl4;		// stage-4 copy of the decode fields
	logic [31:0] rfA;
	logic [31:0] rfB;
	logic [31:0] regA;		// read data registered with ctrl4
	logic [31:0] regB;
	logic [31:0] selB;

	regFile regFile_i (
		.clk       (clk),
		.nrst      (nrst),
		.we        (wbCommit.valid && wbCommit.we),
		.writeAddr (wbCommit.rd),
		.sourceA   (rs1),
		.sourceB   (rs2),
		.result    (wbCommit.data),
		.opA       (rfA),
		.opB       (rfB)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			ctrl4 <= '0;
		else
		begin
			ctrl4       <= ctrl;
			ctrl4.valid <= ctrl.valid && !flush;	// killed behind a taken branch or jal
		end
	end

	always_ff @(posedge clk)
	begin
		regA <= rfA;
		regB <= rfB;
	end

	// operand b mux
	always_comb
	begin
		case (ctrl4.bSel)
			REG:     selB = regB;
			IMM:     selB = ctrl4.iImm;
			SHAMT:   selB = {27'd0, ctrl4.shamt};	// zero extended
			default: selB = regB;
		endcase
	end

	assign issued = '{valid: ctrl4.valid, we: ctrl4.we, rd: ctrl4.rd, aluOp: ctrl4.aluOp,
		resSel: ctrl4.resSel, pcSel: ctrl4.pcSel, bneq: ctrl4.bneq, bImm: ctrl4.bImm,
		pc: ctrl4.pc, opA: regA, opB: selB};

endmodule

/* rtl/executeStage.sv */
module executeStage import corePkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  issueOutT    issued,
	output logic        redirect,
	output logic [31:0] redirectPc,
	output commitT      commit
);

	logic [31:0] aluOut;
	logic [31:0] linkPc;
	logic [31:0] result;
	logic [4:0]  shift;
	logic        equal;
	logic        taken;

	assign shift = issued.opB[4:0];	// only the low 5 bits count

	always_comb
	begin
		case (issued.aluOp)
			ADD:     aluOut = issued.opA + issued.opB;
			SUB:     aluOut = issued.opA - issued.opB;
			AND:     aluOut = issued.opA & issued.opB;
			OR:      aluOut = issued.opA | issued.opB;
			XOR:     aluOut = issued.opA ^ issued.opB;
			SLT:     aluOut = {31'd0, $signed(issued.opA) < $signed(issued.opB)};
			SLTU:    aluOut = {31'd0, issued.opA < issued.opB};
			SLL:     aluOut = issued.opA << shift;
			SRL:     aluOut = issued.opA >> shift;
			SRA:     aluOut = $unsigned($signed(issued.opA) >>> shift);	// sign fill
			default: aluOut = issued.opA + issued.opB;
		endcase
	end

	// branch and jump resolution
	assign equal      = (issued.opA == issued.opB);
	assign taken      = issued.valid && (issued.pcSel == BRANCH) && (equal != issued.bneq);
	assign redirect   = taken || (issued.valid && issued.pcSel == JUMP);
	assign redirectPc = issued.pc + issued.bImm;	// same adder target for beq, bne and jal

	assign linkPc = issued.pc + 32'd4;
	assign result = (issued.resSel == LINK) ? linkPc : aluOut;

	// commit register, doubles as the register file write port
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			commit <= '0;
		else
			commit <= '{valid: issued.valid, we: issued.we, rd: issued.rd, data: result,
				pc: issued.pc};	// branches come through with we low
	end

endmodule

/* rtl/pipelineTop.sv */
module pipelineTop import corePkg::*, wishbonePkg::*; #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  logic   clk,
	input  logic   nrst,
	output wbReqT  wbReq,	// instruction fetch master
	input  wbRspT  wbRsp,
	output commitT commit	// retirement trace
);

	logic           instrValid;
	logic [31:0]    instr;
	logic [31:0]    instrPc;
	logic           stall;
	logic           redirect;
	logic [31:0]    redirectPc;
	logic [4:0]     rs1;
	logic [4:0]     rs2;
	decodeCtrlT     ctrl;
	issueOutT       issued;
	writeTagT [1:0] pipeWrites;

	// destinations still ahead of the write, seen by the hazard check
	assign pipeWrites[0] = '{valid: issued.valid, we: issued.we, rd: issued.rd};
	assign pipeWrites[1] = '{valid: commit.valid, we: commit.we, rd: commit.rd};

	fetchUnit #(
		.resetPc (resetPc)
	) fetchUnit_i (
		.clk        (clk),
		.nrst       (nrst),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.stall      (stall),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.instrValid (instrValid),
		.instr      (instr),
		.instrPc    (instrPc)
	);

	decodeStage decodeStage_i (
		.clk        (clk),
		.nrst       (nrst),
		.instrValid (instrValid),
		.flush      (redirect),	// redirect squashes the younger stages
		.instr      (instr),
		.instrPc    (instrPc),
		.pipeWrites (pipeWrites),
		.stall      (stall),
		.rs1        (rs1),
		.rs2        (rs2),
		.ctrl       (ctrl)
	);

	issueStage issueStage_i (
		.clk      (clk),
		.nrst     (nrst),
		.flush    (redirect),
		.ctrl     (ctrl),
		.rs1      (rs1),
		.rs2      (rs2),
		.wbCommit (commit),
		.issued   (issued)
	);

	executeStage executeStage_i (
		.clk        (clk),
		.nrst       (nrst),
		.issued     (issued),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.commit     (commit)
	);

endmodule

/* verification/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr = 16'd49581;

function automatic logic [31:0] takeBits(int n);	// one lfsr step per bit
	logic [31:0] v;
	v = 32'd0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		v    = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

// rv32i encoders
function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3, logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
	logic [4:0] rd);
	return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] encB(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(logic [20:0] off, logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// {funct7 bit 5, funct3} of the ten register ops
localparam logic [3:0] rFuncs [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
localparam logic [2:0] iFuncs [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};	// no shifts here

function automatic void genProgram();
	logic [3:0]  rf;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [11:0] imm;
	logic [2:0]  kind;
	logic [1:0]  sh;
	// directed start with signed edge values, x0 writes, both branch outcomes and jal
	progMem[0]  = encI(12'hfff, 5'd0, 3'b000, 5'd1);		// x1 = -1
	progMem[1]  = encI(12'h001, 5'd0, 3'b000, 5'd2);		// x2 = 1
	progMem[2]  = encI(12'h01f, 5'd2, 3'b001, 5'd3);		// slli gives 0x80000000
	progMem[3]  = encR(7'h00, 5'd2, 5'd3, 3'b010, 5'd4);	// slt, min < 1
	progMem[4]  = encR(7'h00, 5'd2, 5'd3, 3'b011, 5'd5);	// sltu, unsigned min > 1
	progMem[5]  = encI(12'h404, 5'd3, 3'b101, 5'd6);		// srai by 4 on a negative
	progMem[6]  = encR(7'h20, 5'd2, 5'd1, 3'b101, 5'd7);	// sra of -1
	progMem[7]  = encR(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);	// sub 1 - (-1)
	progMem[8]  = encI(12'h005, 5'd1, 3'b000, 5'd0);		// write to x0
	progMem[9]  = encR(7'h00, 5'd4, 5'd0, 3'b000, 5'd5);	// x0 must still read zero
	progMem[10] = encB(13'd8, 5'd4, 5'd5, 3'b000);			// beq taken
	progMem[11] = encI(12'h063, 5'd0, 3'b000, 5'd6);		// shadow
	progMem[12] = encB(13'd8, 5'd4, 5'd5, 3'b001);			// bne falls through
	progMem[13] = encJ(21'd8, 5'd7);				// jal over one word
	progMem[14] = encI(12'h04d, 5'd0, 3'b000, 5'd6);		// shadow
	progMem[15] = encR(7'h00, 5'd0, 5'd7, 3'b000, 5'd6);	// reads the link value
	for (int i = 16; i < progLen; i++)
	begin
		rd   = 5'(takeBits(3));	// x0..x7 only, so dependencies are dense
		rs1  = 5'(takeBits(3));
		rs2  = 5'(takeBits(3));
		imm  = 12'(takeBits(12));
		kind = 3'(takeBits(3));
		case (kind)
			3'd0, 3'd1, 3'd2:
			begin
				rf = rFuncs[4'(takeBits(4) % 10)];
				progMem[7'(i)] = encR({1'b0, rf[3], 5'd0}, rs2, rs1, rf[2:0], rd);
			end
			3'd3, 3'd4: progMem[7'(i)] = encI(imm, rs1, iFuncs[3'(takeBits(3) % 6)], rd);
			3'd5:
			begin
				sh = 2'(takeBits(2) % 3);	// slli, srli, srai
				progMem[7'(i)] = encI({1'b0, sh == 2'd2, 5'd0, imm[4:0]}, rs1,
					(sh == 2'd0) ? 3'b001 : 3'b101, rd);
			end
			3'd6: progMem[7'(i)] = encB(13'(4 * (takeBits(2) + 1)), rs2, rs1,
				{2'b00, imm[11]});	// forward only, beq or bne
			default: progMem[7'(i)] = encJ(21'(4 * (takeBits(3) + 1)), rd);
		endcase
	end
endfunction

// isa semantics by funct3, alt is bit 30 of the word
function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
	logic [31:0] b);
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return {31'd0, $signed(a) < $signed(b)};
		3'b011:  return {31'd0, a < b};
		3'b100:  return a ^ b;
		3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

// runs the program on a model register file and queues the expected trace
function automatic void runReference();
	logic [31:0] x [32];
	logic [31:0] addr;
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] iImm;
	logic [31:0] bOff;
	logic [31:0] jOff;
	commitT      e;
	x    = '{default: 32'd0};
	addr = startPc;
	while (addr < progLen * 4)	// every jump goes forward, so this ends
	begin
		ins  = progMem[addr[8:2]];
		a    = x[ins[19:15]];
		b    = x[ins[24:20]];
		iImm = {{20{ins[31]}}, ins[31:20]};
		bOff = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		jOff = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		e    = '{valid: 1'b1, we: 1'b1, rd: ins[11:7], data: 32'd0, pc: addr};
		addr = addr + 32'd4;
		case (ins[6:0])
			7'b0110011: e.data = aluRef(ins[14:12], ins[30], a, b);
			7'b0010011: e.data = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, iImm);
			7'b1100011:
			begin
				e.we = 1'b0;	// branch shows up with no write
				e.rd = 5'd0;
				if ((a == b) != ins[12])
					addr = e.pc + bOff;
			end
			default:	// jal
			begin
				e.data = e.pc + 32'd4;
				addr   = e.pc + jOff;
			end
		endcase
		if (e.we)
			x[e.rd] = e.data;
		x[0] = 32'd0;
		expectQ.push_back(e);
	end
endfunction

`endif

/* verification/pipelineTb.sv */
module pipelineTb
	import corePkg::*, wishbonePkg::*;
();

	localparam int          progLen   = 128;	// program size in words, a power of two for the index
	localparam int          clkPeriod = 100;
	localparam logic [31:0] startPc   = 32'h0000_0000;
	// worst case per instruction is 3 stall plus 5 fetch with ack wait and gap plus 6 refill
	localparam int          cyclesPerInstr = 3 + 5 + 6;
	localparam int          watchdogCycles = progLen * cyclesPerInstr * 2 + 50;

	logic   clk   = 1'b0;
	logic   nrst  = 1'b0;
	wbReqT  wbReq;
	wbRspT  wbRsp = '0;
	commitT commit;

	logic [31:0] progMem [progLen];
	commitT      expectQ [$];	// reference trace with the oldest entry first
	commitT      expEntry;
	int          expectTotal = 0;
	int          checked     = 0;
	int          errors      = 0;
	logic        pending     = 1'b0;	// slave has seen the current request
	logic [1:0]  waitLeft    = 2'd0;
	logic [31:0] busAdr      = 32'd0;	// address of the request being served

	`include "isaModel.svh"

	pipelineTop #(
		.resetPc (startPc)
	) pipelineTop_i (
		.clk    (clk),
		.nrst   (nrst),
		.wbReq  (wbReq),
		.wbRsp  (wbRsp),
		.commit (commit)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] fetchWord(logic [31:0] adr);
		if (adr < progLen * 4)
			return progMem[adr[8:2]];
		return 32'h0000_0013;	// nop past the end of the program
	endfunction

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			errors++;
			$display("** Error: %s is %h, expected %h at time %0t", name, got, expected,
				$time);
		end
	endtask

	// wishbone classic slave with 0 to 3 wait cycles per transfer
	always @(negedge clk)
	begin
		if (wbRsp.ack)
		begin
			wbRsp.ack = 1'b0;	// taken at the last rising edge
			pending   = 1'b0;
		end
		else if (wbReq.cyc && wbReq.stb)
		begin
			checkValue("wbReq.we", {31'd0, wbReq.we}, 32'd0);	// fetch never writes
			if (!pending)
			begin
				pending  = 1'b1;
				busAdr   = wbReq.adr;
				waitLeft = 2'(takeBits(2));
			end
			else
				checkValue("wbReq.adr", wbReq.adr, busAdr);	// held until the ack
			if (waitLeft == 2'd0)
			begin
				wbRsp.ack = 1'b1;
				wbRsp.dat = fetchWord(wbReq.adr);
			end
			else
				waitLeft = waitLeft - 2'd1;
		end
	end

	// the commit register settles after the rising edge so look in the middle of the cycle
	always @(negedge clk)
	begin
		if (nrst && commit.valid && expectQ.size() > 0)
		begin
			expEntry = expectQ.pop_front();
			checkValue("commit.pc", commit.pc, expEntry.pc);
			checkValue("commit.we", {31'd0, commit.we}, {31'd0, expEntry.we});
			if (expEntry.we)	// rd and data mean nothing on a branch
			begin
				checkValue("commit.rd", {27'd0, commit.rd}, {27'd0, expEntry.rd});
				checkValue("commit.data", commit.data, expEntry.data);
			end
			checked++;
		end
	end

	initial
	begin
		genProgram();
		runReference();
		expectTotal = expectQ.size();
		$display("program of %0d words, %0d commits expected", progLen, expectTotal);
		repeat (4) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		wait (checked == expectTotal);
		@(posedge clk);
		$display("%0d of %0d commits checked, %0d value errors", checked, expectTotal, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("timeout after %0d cycles, %0d of %0d commits seen, %0d value errors",
			watchdogCycles, checked, expectTotal, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+verification
rtl/corePkg.sv
rtl/wishbonePkg.sv
rtl/regFile.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/issueStage.sv
rtl/executeStage.sv
rtl/pipelineTop.sv
verification/pipelineTb.sv

/* Makefile */
SIM  = obj_dir/VpipelineTb
SRCS = $(wildcard rtl/*.sv) verification/pipelineTb.sv verification/isaModel.svh

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --top-module pipelineTb -f compile.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
